/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

	// Code memory depth, log2 of the word count
	localparam int RAM_A_WIDTH = 12;
	// Word PC covers exactly the code memory
	localparam int PC_W = RAM_A_WIDTH;
	localparam int MMIO_WORDS = 8;
	localparam string ROM_FILE = "tb_program.hex";

	typedef logic [31:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [PC_W-1:0] word_pc_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [2:0] mmio_idx_t;

	// Inputs and outputs both sit at FFFFFFE0 to FFFFFFFC
	localparam word_t MMIO_BASE = 32'hFFFF_FFE0;
	// Return address offset for JAL and JALR
	localparam word_t LINK_OFFSET = 32'd4;

	// Supported major opcodes only
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_t;

	// Fetch to decode, instruction word arrives from the ROM port
	typedef struct packed {
		logic valid;
		word_pc_t pc;
	} fd_pkt_t;

	// Decode to execute
	typedef struct packed {
		logic valid;
		alu_op_t alu_op;
		word_t operand_a;
		word_t operand_b;
		word_t store_data;
		reg_addr_t rd;
		logic rd_we;
		logic is_load;
		logic is_store;
		mmio_idx_t mmio_idx;
	} de_pkt_t;

	// Execute to register file
	typedef struct packed {
		logic we;
		reg_addr_t addr;
		word_t data;
	} wb_t;

	// Decode back to fetch
	typedef struct packed {
		logic taken;
		word_pc_t target;
	} ct_t;

endpackage

`default_nettype wire

/* rv_instr_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_instr_mem import rv_pkg::*; (
	input logic clock,
	input word_pc_t addr,
	output instr_t data
);

	// One instruction per word
	instr_t mem [2**RAM_A_WIDTH];

	// Program image, one hex word per line
	initial begin
		$readmemh(ROM_FILE, mem);
	end

	// Synchronous read, data lines up with the fd packet
	always_ff @(posedge clock) begin
		data <= mem[addr];
	end

	// PC is reset asynchronously, so an unknown address means
	// a broken target computation upstream in decode
	a_addr_known: assert property (
		@(posedge clock) !$isunknown(addr)
	) else $error("instruction address unknown");

endmodule

`default_nettype wire

/* rv_regfile.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
	input logic clock,
	input logic arst_n,
	input wb_t wb,
	input reg_addr_t rs1_addr,
	input reg_addr_t rs2_addr,
	output word_t rs1_data,
	output word_t rs2_data,
	output word_t reg31
);

	// x0 has no storage
	word_t regs [1:31];

	// Falling edge write, decode sees the value before the next rising edge
	always_ff @(negedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && (wb.addr != '0)) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// Combinational reads, x0 hardwired to zero
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	// Tap for older test programs
	assign reg31 = regs[31];

	// Write strobe from execute must always name a real register
	a_wb_addr_known: assert property (
		@(negedge clock) disable iff (!arst_n) wb.we |-> !$isunknown(wb.addr)
	) else $error("write enable with unknown register index");

endmodule

`default_nettype wire

/* rv_fetch.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; (
	input logic clock,
	input logic arst_n,
	input ct_t ct,
	output word_pc_t rom_addr,
	output fd_pkt_t fd
);

	// Word PC of the instruction being read from the ROM
	word_pc_t pc;

	// ROM address comes straight from the PC register
	assign rom_addr = pc;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			fd <= '0;
		end else begin
			// PC of the word the ROM captures on this edge
			fd.pc <= pc;
			// Word read alongside a taken transfer is wrong path
			fd.valid <= !ct.taken;
			if (ct.taken) begin
				// Redirect from decode
				pc <= ct.target;
			end else begin
				// Sequential flow
				pc <= pc + word_pc_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

/* rv_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
	input logic clock,
	input logic arst_n,
	input fd_pkt_t fd,
	input instr_t instr,
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	input word_t rs1_data,
	input word_t rs2_data,
	output ct_t ct,
	output de_pkt_t de
);

	opcode_t opcode;
	logic [2:0] funct3;
	logic funct7_b5;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	word_t pc_byte;
	word_t rs1_imm;
	alu_op_t alu_funct;
	logic legal;
	logic is_jal;
	logic is_jalr;
	logic branch_taken;
	de_pkt_t de_next;

	// Instruction fields
	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7_b5 = instr[30];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];

	// Sign extended immediates
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Byte address of this instruction
	assign pc_byte = {{(32 - PC_W - 2){1'b0}}, fd.pc, 2'b00};

	// Shared by JALR targets, loads and stores
	assign rs1_imm = rs1_data + ((opcode == OPC_STORE) ? imm_s : imm_i);

	// funct3 to ALU op, funct7 bit 5 picks SUB or SRA
	always_comb begin
		case (funct3)
			3'b000: alu_funct = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
			3'b001: alu_funct = ALU_SLL;
			3'b010: alu_funct = ALU_SLT;
			3'b011: alu_funct = ALU_SLTU;
			3'b100: alu_funct = ALU_XOR;
			3'b101: alu_funct = funct7_b5 ? ALU_SRA : ALU_SRL;
			3'b110: alu_funct = ALU_OR;
			3'b111: alu_funct = ALU_AND;
		endcase
	end

	always_comb begin
		// Defaults match OP-IMM
		de_next = '0;
		de_next.alu_op = alu_funct;
		de_next.operand_a = rs1_data;
		de_next.operand_b = imm_i;
		de_next.store_data = rs2_data;
		de_next.rd = instr[11:7];
		de_next.mmio_idx = rs1_imm[4:2];
		legal = 1'b0;
		is_jal = 1'b0;
		is_jalr = 1'b0;
		branch_taken = 1'b0;
		case (opcode)
			OPC_OP: begin
				legal = 1'b1;
				de_next.rd_we = 1'b1;
				de_next.operand_b = rs2_data;
			end
			OPC_OP_IMM: begin
				legal = 1'b1;
				de_next.rd_we = 1'b1;
			end
			OPC_LUI: begin
				legal = 1'b1;
				de_next.rd_we = 1'b1;
				de_next.alu_op = ALU_PASS_B;
				de_next.operand_b = imm_u;
			end
			OPC_AUIPC: begin
				legal = 1'b1;
				de_next.rd_we = 1'b1;
				de_next.alu_op = ALU_ADD;
				de_next.operand_a = pc_byte;
				de_next.operand_b = imm_u;
			end
			OPC_JAL, OPC_JALR: begin
				legal = (opcode == OPC_JAL) || (funct3 == 3'b000);
				is_jal = (opcode == OPC_JAL);
				is_jalr = legal && (opcode == OPC_JALR);
				// Link is PC plus 4 through the ALU
				de_next.rd_we = 1'b1;
				de_next.alu_op = ALU_ADD;
				de_next.operand_a = pc_byte;
				de_next.operand_b = LINK_OFFSET;
			end
			OPC_BRANCH: begin
				// BEQ and BNE only
				legal = (funct3[2:1] == 2'b00);
				branch_taken = legal && ((rs1_data == rs2_data) ^ funct3[0]);
			end
			OPC_LOAD: begin
				// Whole words only
				legal = (funct3 == 3'b010);
				de_next.rd_we = 1'b1;
				de_next.is_load = 1'b1;
				de_next.alu_op = ALU_ADD;
			end
			OPC_STORE: begin
				legal = (funct3 == 3'b010);
				de_next.is_store = 1'b1;
				de_next.alu_op = ALU_ADD;
				de_next.operand_b = imm_s;
			end
			default: legal = 1'b0;
		endcase
		// Wrong-path and unsupported words become bubbles
		de_next.valid = fd.valid && legal;
	end

	// Redirect, targets in words
	always_comb begin
		ct.taken = fd.valid && (is_jal || is_jalr || branch_taken);
		if (is_jalr) begin
			ct.target = rs1_imm[PC_W+1:2];
		end else if (is_jal) begin
			ct.target = fd.pc + imm_j[PC_W+1:2];
		end else begin
			ct.target = fd.pc + imm_b[PC_W+1:2];
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			de <= '0;
		end else begin
			de <= de_next;
		end
	end

	// One bubble after a taken transfer, then fetch delivers the target word
	a_ct_flush: assert property (
		@(posedge clock) disable iff (!arst_n)
		ct.taken |=> !fd.valid ##1 (fd.valid && fd.pc == $past(ct.target, 2))
	) else $error("taken transfer not followed by one bubble and the target word");

endmodule

`default_nettype wire

/* rv_execute.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
	input logic clock,
	input logic arst_n,
	input de_pkt_t de,
	input word_t mmio_in [MMIO_WORDS],
	output word_t mmio_out [MMIO_WORDS],
	output wb_t wb
);

	word_t alu_result;
	word_t result;
	logic [4:0] shamt;

	// Shift amount from the low bits of operand B
	assign shamt = de.operand_b[4:0];

	always_comb begin
		case (de.alu_op)
			ALU_ADD: alu_result = de.operand_a + de.operand_b;
			ALU_SUB: alu_result = de.operand_a - de.operand_b;
			ALU_SLL: alu_result = de.operand_a << shamt;
			ALU_SLT: alu_result = {31'b0, $signed(de.operand_a) < $signed(de.operand_b)};
			ALU_SLTU: alu_result = {31'b0, de.operand_a < de.operand_b};
			ALU_XOR: alu_result = de.operand_a ^ de.operand_b;
			ALU_SRL: alu_result = de.operand_a >> shamt;
			// Arithmetic shift keeps the sign
			ALU_SRA: alu_result = $signed(de.operand_a) >>> shamt;
			ALU_OR: alu_result = de.operand_a | de.operand_b;
			ALU_AND: alu_result = de.operand_a & de.operand_b;
			ALU_PASS_B: alu_result = de.operand_b;
			default: alu_result = '0;
		endcase
	end

	// Loads bypass the ALU result with the input word
	assign result = de.is_load ? mmio_in[de.mmio_idx] : alu_result;

	// Writeback lands on the falling edge of this cycle
	// x0 writes are dropped here
	assign wb = '{
		we: de.valid && de.rd_we && (de.rd != '0),
		addr: de.rd,
		data: result
	};

	// Output words
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < MMIO_WORDS; i++) begin
				mmio_out[i] <= '0;
			end
		end else if (de.valid && de.is_store) begin
			mmio_out[de.mmio_idx] <= de.store_data;
		end
	end

	// Word index from decode must match the address the ALU computes
	// and that address must sit word aligned in the MMIO window
	a_mmio_window: assert property (
		@(posedge clock) disable iff (!arst_n)
		de.valid && (de.is_load || de.is_store) |->
			(alu_result[31:5] == MMIO_BASE[31:5]) &&
			(alu_result[4:2] == de.mmio_idx) &&
			(alu_result[1:0] == 2'b00)
	) else $error("load or store outside the MMIO window");

endmodule

`default_nettype wire

/* rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
	input logic clock,
	input logic arst_n,
	input word_t mmio_in [MMIO_WORDS],
	output word_t mmio_out [MMIO_WORDS],
	output word_t reg31
);

	// Fetch side
	word_pc_t rom_addr;
	instr_t rom_data;
	fd_pkt_t fd;
	ct_t ct;

	// Decode side
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t rs1_data;
	word_t rs2_data;
	de_pkt_t de;

	// Writeback, falling edge
	wb_t wb;

	// Stages
	rv_fetch fetch (
		.clock(clock),
		.arst_n(arst_n),
		.ct(ct),
		.rom_addr(rom_addr),
		.fd(fd)
	);

	rv_decode decode (
		.clock(clock),
		.arst_n(arst_n),
		.fd(fd),
		.instr(rom_data),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ct(ct),
		.de(de)
	);

	rv_execute execute (
		.clock(clock),
		.arst_n(arst_n),
		.de(de),
		.mmio_in(mmio_in),
		.mmio_out(mmio_out),
		.wb(wb)
	);

	// Shared blocks
	rv_instr_mem memory_backend (
		.clock(clock),
		.addr(rom_addr),
		.data(rom_data)
	);

	rv_regfile register_file (
		.clock(clock),
		.arst_n(arst_n),
		.wb(wb),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.reg31(reg31)
	);

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*;;

	// Stimulus epochs and check windows, in clock cycles
	localparam int EPOCH_CYCLES = 64;
	localparam int NUM_EPOCHS = 12;
	localparam int TIMEOUT_CYCLES = NUM_EPOCHS * EPOCH_CYCLES + 50;
	localparam int SETTLE_CYCLES = 40;
	localparam int STALL_LIMIT = 40;
	// Program prologue reaches its first store no earlier than this
	localparam int PRE_STORE_CYCLES = 6;
	localparam int MAGIC_CYCLES = 8;
	// LUI 0x12345 plus ADDI 0x678 in the program prologue
	localparam word_t MAGIC = 32'h1234_5678;

	// Clock starts high so the first edge is a falling one
	logic clock = 1'b1;
	logic arst_n = 1'b1;
	word_t mmio_in [MMIO_WORDS];
	word_t mmio_out [MMIO_WORDS];
	word_t reg31;

	integer seed;
	word_t exp_sum;
	word_t exp_xor;
	int epoch_cycle;
	int epochs_done;
	int run_cycles;
	int cycle_count;
	int count_age;
	word_t last_count;
	int error_count;
	logic used_clear;
	logic unused_clear;

	rv_core UUT (
		.clock(clock),
		.arst_n(arst_n),
		.mmio_in(mmio_in),
		.mmio_out(mmio_out),
		.reg31(reg31)
	);

	always #5 clock = ~clock;

	// New operand pair and the results the program must produce from it
	task automatic draw_operands();
		word_t a;
		word_t b;
		a = $random(seed);
		b = $random(seed);
		mmio_in[0] <= a;
		mmio_in[1] <= b;
		exp_sum <= a + b;
		exp_xor <= a ^ b;
	endtask

	initial begin
		seed = 81;
		error_count = 0;
		for (int i = 0; i < MMIO_WORDS; i++) begin
			mmio_in[i] = '0;
		end
		draw_operands();
		// Reset for 5 rising edges
		@(negedge clock);
		arst_n <= 1'b0;
		repeat (5) @(negedge clock);
		arst_n <= 1'b1;
		while (epochs_done < NUM_EPOCHS) begin
			@(posedge clock);
		end
		@(posedge clock);
		$display("Run ended after %0d cycles with %0d errors", cycle_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Inputs move on the falling edge only
	always @(negedge clock) begin
		if (arst_n) begin
			if (epoch_cycle == EPOCH_CYCLES - 1) begin
				draw_operands();
				epoch_cycle <= 0;
				epochs_done <= epochs_done + 1;
			end else begin
				epoch_cycle <= epoch_cycle + 1;
			end
		end
	end

	// Cycles since release, and age of the current loop count
	always @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			run_cycles <= 0;
			count_age <= 0;
			last_count <= '0;
		end else begin
			run_cycles <= run_cycles + 1;
			if (mmio_out[2] != last_count) begin
				last_count <= mmio_out[2];
				count_age <= 0;
			end else begin
				count_age <= count_age + 1;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: test epochs not finished after %0d cycles", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// Words 0 to 3 plus the tap, and the words the program never touches
	always_comb begin
		used_clear = (reg31 == '0);
		unused_clear = 1'b1;
		for (int i = 0; i < 4; i++) begin
			used_clear = used_clear && (mmio_out[i] == '0);
			unused_clear = unused_clear && (mmio_out[i + 4] == '0);
		end
	end

	a_reset_clear: assert property (
		@(posedge clock) (!arst_n || run_cycles < PRE_STORE_CYCLES) |-> used_clear && unused_clear
	) else begin
		error_count++;
		$display("ERR %0t: output word or reg31 not zero before the first store", $time);
	end

	a_unused_clear: assert property (@(posedge clock) unused_clear) else begin
		error_count++;
		$display("ERR %0t: output word 4 to 7 written", $time);
	end

	// Settled ADD result
	a_sum: assert property (
		@(posedge clock) disable iff (!arst_n)
		(epoch_cycle >= SETTLE_CYCLES) |-> mmio_out[0] == exp_sum
	) else begin
		error_count++;
		$display("ERR %0t: mmio_out[0] = %h, expected sum %h",
			$time, $sampled(mmio_out[0]), $sampled(exp_sum));
	end

	a_xor: assert property (
		@(posedge clock) disable iff (!arst_n)
		(epoch_cycle >= SETTLE_CYCLES) |-> mmio_out[1] == exp_xor
	) else begin
		error_count++;
		$display("ERR %0t: mmio_out[1] = %h, expected xor %h",
			$time, $sampled(mmio_out[1]), $sampled(exp_xor));
	end

	// Loop counter only ever steps by one
	a_count_step: assert property (
		@(posedge clock) disable iff (!arst_n)
		$changed(mmio_out[2]) |-> mmio_out[2] == $past(mmio_out[2]) + 32'd1
	) else begin
		error_count++;
		$display("ERR %0t: mmio_out[2] = %h, expected %h",
			$time, $sampled(mmio_out[2]), $past(mmio_out[2]) + 32'd1);
	end

	a_count_alive: assert property (
		@(posedge clock) disable iff (!arst_n) count_age < STALL_LIMIT
	) else begin
		error_count++;
		$display("ERR %0t: mmio_out[2] stuck for %0d cycles", $time, $sampled(count_age));
	end

	a_reg31_tap: assert property (
		@(posedge clock) disable iff (!arst_n)
		$changed(mmio_out[2]) |=> reg31 == mmio_out[2]
	) else begin
		error_count++;
		$display("ERR %0t: reg31 = %h, expected %h",
			$time, $sampled(reg31), $sampled(mmio_out[2]));
	end

	// A wrong-path store would leave 0xBAD here
	a_magic: assert property (
		@(posedge clock) disable iff (!arst_n)
		mmio_out[3] == MAGIC || (run_cycles < MAGIC_CYCLES && mmio_out[3] == '0)
	) else begin
		error_count++;
		$display("ERR %0t: mmio_out[3] = %h, expected %h",
			$time, $sampled(mmio_out[3]), MAGIC);
	end

endmodule

`default_nettype wire

/* tb_program.hex */
// One 32-bit instruction word per line, starting at word address 0
// Trailing text on each line is the assembly for that word
FE000093 // 00 addi x1, x0, -32      MMIO base
123452B7 // 01 lui  x5, 0x12345
67828293 // 02 addi x5, x5, 0x678
0050A623 // 03 sw   x5, 12(x1)       constant to word 3
00001337 // 04 lui  x6, 1
BAD30313 // 05 addi x6, x6, -1107    x6 = 0xBAD
0000A103 // 06 lw   x2, 0(x1)        loop
0040A183 // 07 lw   x3, 4(x1)
00310233 // 08 add  x4, x2, x3
0040A023 // 09 sw   x4, 0(x1)
00314233 // 10 xor  x4, x2, x3
0040A223 // 11 sw   x4, 4(x1)
001F8F93 // 12 addi x31, x31, 1
03FF9063 // 13 bne  x31, x31, 21     never taken
01F0A423 // 14 sw   x31, 8(x1)
00000463 // 15 beq  x0, x0, 17       always taken
0060A623 // 16 sw   x6, 12(x1)       wrong path
008003EF // 17 jal  x7, 19
0060A623 // 18 sw   x6, 12(x1)       wrong path
FD038067 // 19 jalr x0, -48(x7)      back to 6 through the link
0060A623 // 20 sw   x6, 12(x1)       wrong path
0060A623 // 21 sw   x6, 12(x1)       trap
0000006F // 22 jal  x0, 22           spin
00000013 // 23 nop

/* vlog.f */
rv_pkg.sv
rv_instr_mem.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - rv_pkg.sv
      - rv_instr_mem.sv
      - rv_regfile.sv
      - rv_fetch.sv
      - rv_decode.sv
      - rv_execute.sv
      - rv_core.sv
  - target: test
    files:
      - tb_rv_core.sv
